// File: hdl/bp_pkg.sv
package bp_pkg;

  // machine word, used for both pc and instruction
  localparam int xlen = 32;

  // table geometry
  localparam int index_bits = 8;
  localparam int tag_bits   = xlen - index_bits;
  localparam int entries    = 1 << index_bits;

  // opcodes that mark a jump instruction
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_branch = 7'b1100011;

  // 2-bit saturating counter values
  localparam logic [1:0] ctr_min  = 2'b00;
  localparam logic [1:0] ctr_init = 2'b01;
  localparam logic [1:0] ctr_max  = 2'b11;

  // word address split for BTAC lookup
  typedef struct packed {
    logic [tag_bits-1:0]   tag;
    logic [index_bits-1:0] index;
  } pc_fields_t;

  // same 32 bits, read either as an address or as tag plus index
  typedef union packed {
    logic [xlen-1:0] addr;
    pc_fields_t      f;
  } pc_u;

endpackage

// File: hdl/bp_stage_if.sv
`timescale 1ns/1ps

// valid/ready handshake from lookup stage to select stage
interface lookup_if #(
  parameter int hist_bits = 2
);
  logic                 valid;
  logic                 ready;
  bp_pkg::pc_u          pc;
  logic                 is_jump;
  logic [hist_bits-1:0] hist;

  modport src (output valid, pc, is_jump, hist, input ready);
  modport dst (input valid, pc, is_jump, hist, output ready);
endinterface

// resolve stage to counter table and BTAC
interface table_update_if #(
  parameter int hist_bits = 2
);
  logic                          ctr_we;
  logic [bp_pkg::index_bits-1:0] index;
  logic [hist_bits-1:0]          hist;
  logic                          taken;
  logic                          tgt_we;
  logic [bp_pkg::tag_bits-1:0]   tag;
  logic [bp_pkg::xlen-1:0]       target;

  modport src (output ctr_we, index, hist, taken, tgt_we, tag, target);
  modport dst (input ctr_we, index, hist, taken, tgt_we, tag, target);
endinterface

// File: hdl/pattern_table.sv
`timescale 1ns/1ps

module pattern_table #(
  parameter int hist_bits = 2
) (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          rd_en,
  input  logic [bp_pkg::index_bits-1:0] rd_index,
  input  logic [hist_bits-1:0]          rd_hist,
  output logic [1:0]                    rd_ctr,
  table_update_if.dst                   upd
);

  localparam int ways = 1 << hist_bits;

  // one counter per pc index and history pattern
  logic [1:0] ctr_mem [bp_pkg::entries][ways];
  logic [1:0] cur_ctr;
  logic [1:0] nxt_ctr;

  assign cur_ctr = ctr_mem[upd.index][upd.hist];

  // saturating step toward the resolved direction
  always_comb begin
    nxt_ctr = cur_ctr;
    if (upd.taken) begin
      if (cur_ctr != bp_pkg::ctr_max) begin
        nxt_ctr = cur_ctr + 2'd1;
      end
    end else begin
      if (cur_ctr != bp_pkg::ctr_min) begin
        nxt_ctr = cur_ctr - 2'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rstn) begin
      // all counters start weakly not taken
      for (int i = 0; i < bp_pkg::entries; i++) begin
        for (int j = 0; j < ways; j++) begin
          ctr_mem[i][j] <= bp_pkg::ctr_init;
        end
      end
    end else if (upd.ctr_we) begin
      ctr_mem[upd.index][upd.hist] <= nxt_ctr;
    end
  end

  // read data holds while rd_en is low
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_ctr <= ctr_mem[rd_index][rd_hist];
    end
  end

endmodule

// File: hdl/target_cache.sv
`timescale 1ns/1ps

module target_cache (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    rd_en,
  input  bp_pkg::pc_u             rd_pc,
  output logic                    hit,
  output logic [bp_pkg::xlen-1:0] target,
  table_update_if.dst             upd
);

  logic [bp_pkg::tag_bits-1:0] tag_mem [bp_pkg::entries];
  logic [bp_pkg::xlen-1:0]     tgt_mem [bp_pkg::entries];

  logic [bp_pkg::tag_bits-1:0] tag_q;
  logic [bp_pkg::tag_bits-1:0] pc_tag_q;
  logic [bp_pkg::xlen-1:0]     tgt_q;

  always_ff @(posedge clk) begin
    if (rstn) begin
      for (int i = 0; i < bp_pkg::entries; i++) begin
        tag_mem[i] <= '0;
        tgt_mem[i] <= '0;
      end
    end else if (upd.tgt_we) begin
      tag_mem[upd.index] <= upd.tag;
      tgt_mem[upd.index] <= upd.target;
    end
  end

  // keep the query tag next to the stored one
  always_ff @(posedge clk) begin
    if (rd_en) begin
      tag_q    <= tag_mem[rd_pc.f.index];
      tgt_q    <= tgt_mem[rd_pc.f.index];
      pc_tag_q <= rd_pc.f.tag;
    end
  end

  assign hit    = (tag_q == pc_tag_q);
  assign target = tgt_q;

endmodule

// File: hdl/lookup_stage.sv
`timescale 1ns/1ps

module lookup_stage #(
  parameter int hist_bits = 2
) (
  input  logic                          clk,
  input  logic                          rstn,
  input  logic                          query_valid,
  output logic                          query_ready,
  input  bp_pkg::pc_u                   query_pc,
  input  logic [bp_pkg::xlen-1:0]       query_instr,
  input  logic [hist_bits-1:0]          hist,
  output logic                          rd_en,
  output logic [bp_pkg::index_bits-1:0] rd_index,
  output logic [hist_bits-1:0]          rd_hist,
  output bp_pkg::pc_u                   rd_pc,
  lookup_if.src                         out
);

  logic [6:0]           opcode;
  logic                 is_jump;
  logic                 accept;
  logic                 valid_q;
  bp_pkg::pc_u          pc_q;
  logic                 is_jump_q;
  logic [hist_bits-1:0] hist_q;

  assign opcode  = query_instr[6:0];
  assign is_jump = (opcode == bp_pkg::op_jal) ||
                   (opcode == bp_pkg::op_jalr) ||
                   (opcode == bp_pkg::op_branch);

  // free slot, or the entry leaves this cycle
  assign query_ready = !valid_q || out.ready;
  assign accept      = query_valid && query_ready;

  // table reads start on the same edge the entry is captured
  assign rd_en    = accept;
  assign rd_index = query_pc.f.index;
  assign rd_hist  = hist;
  assign rd_pc    = query_pc;

  always_ff @(posedge clk) begin
    if (rstn) begin
      valid_q <= 1'b0;
    end else if (accept) begin
      valid_q <= 1'b1;
    end else if (out.ready) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      pc_q      <= query_pc;
      is_jump_q <= is_jump;
      hist_q    <= hist;
    end
  end

  assign out.valid   = valid_q;
  assign out.pc      = pc_q;
  assign out.is_jump = is_jump_q;
  assign out.hist    = hist_q;

endmodule

// File: hdl/select_stage.sv
`timescale 1ns/1ps

module select_stage #(
  parameter int hist_bits = 2
) (
  input  logic                    clk,
  input  logic                    rstn,
  lookup_if.dst                   in,
  input  logic [1:0]              ctr,
  input  logic                    hit,
  input  logic [bp_pkg::xlen-1:0] target,
  output logic                    pred_valid,
  input  logic                    pred_ready,
  output logic [bp_pkg::xlen-1:0] pred_next_pc,
  output logic                    pred_taken,
  output logic [hist_bits-1:0]    pred_hist
);

  logic                    take;
  logic                    load;
  logic [bp_pkg::xlen-1:0] next_pc;

  // jump opcode, counter leaning taken, and a matching BTAC tag
  assign take    = in.is_jump && ctr[1] && hit;
  assign next_pc = take ? target : in.pc.addr + 1'b1;

  // output register is the stall point
  assign in.ready = !pred_valid || pred_ready;
  assign load     = in.valid && in.ready;

  always_ff @(posedge clk) begin
    if (rstn) begin
      pred_valid <= 1'b0;
    end else if (load) begin
      pred_valid <= 1'b1;
    end else if (pred_ready) begin
      pred_valid <= 1'b0;
    end
  end

  // prediction payload loaded on each transfer
  always_ff @(posedge clk) begin
    if (load) begin
      pred_next_pc <= next_pc;
      pred_taken   <= take;
      pred_hist    <= in.hist;
    end
  end

endmodule

// File: hdl/resolve_stage.sv
`timescale 1ns/1ps

module resolve_stage #(
  parameter int hist_bits = 2,
  parameter int stat_bits = 16
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  logic                    res_valid,
  input  bp_pkg::pc_u             res_pc,
  input  logic [hist_bits-1:0]    res_hist,
  input  logic                    res_taken,
  input  logic [bp_pkg::xlen-1:0] res_target,
  input  logic [bp_pkg::xlen-1:0] res_pred_next,
  output logic [hist_bits-1:0]    hist,
  table_update_if.src             upd,
  output logic [stat_bits-1:0]    stat_total,
  output logic [stat_bits-1:0]    stat_correct,
  output logic [stat_bits-1:0]    stat_wrong
);

  logic                    valid_q;
  bp_pkg::pc_u             pc_q;
  logic [hist_bits-1:0]    hist_q;
  logic                    taken_q;
  logic [bp_pkg::xlen-1:0] target_q;
  logic [bp_pkg::xlen-1:0] pred_next_q;
  logic [bp_pkg::xlen-1:0] actual_next;
  logic                    mispredict;

  always_ff @(posedge clk) begin
    if (rstn) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= res_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (res_valid) begin
      pc_q        <= res_pc;
      hist_q      <= res_hist;
      taken_q     <= res_taken;
      target_q    <= res_target;
      pred_next_q <= res_pred_next;
    end
  end

  assign actual_next = taken_q ? target_q : pc_q.addr + 1'b1;
  assign mispredict  = (actual_next != pred_next_q);

  // counter trained on every resolve, target only on a missed taken jump
  assign upd.ctr_we = valid_q;
  assign upd.index  = pc_q.f.index;
  assign upd.hist   = hist_q;
  assign upd.taken  = taken_q;
  assign upd.tgt_we = valid_q && mispredict && taken_q;
  assign upd.tag    = pc_q.f.tag;
  assign upd.target = target_q;

  always_ff @(posedge clk) begin
    if (rstn) begin
      hist         <= '0;
      stat_total   <= '0;
      stat_correct <= '0;
      stat_wrong   <= '0;
    end else if (valid_q) begin
      // newest outcome enters at bit 0
      hist       <= (hist << 1) | hist_bits'(taken_q);
      stat_total <= stat_total + 1'b1;
      if (mispredict) begin
        stat_wrong <= stat_wrong + 1'b1;
      end else begin
        stat_correct <= stat_correct + 1'b1;
      end
    end
  end

endmodule

// File: hdl/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor #(
  parameter int hist_bits = 2,
  parameter int stat_bits = 16
) (
  input  logic                 clk,
  input  logic                 rstn,

  // fetch side queries
  input  logic                 query_valid,
  output logic                 query_ready,
  input  logic [31:0]          query_pc,
  input  logic [31:0]          query_instr,

  // predictions
  output logic                 pred_valid,
  input  logic                 pred_ready,
  output logic [31:0]          pred_next_pc,
  output logic                 pred_taken,
  output logic [hist_bits-1:0] pred_hist,

  // executed jumps
  input  logic                 res_valid,
  input  logic [31:0]          res_pc,
  input  logic [hist_bits-1:0] res_hist,
  input  logic                 res_taken,
  input  logic [31:0]          res_target,
  input  logic [31:0]          res_pred_next,

  output logic [stat_bits-1:0] stat_total,
  output logic [stat_bits-1:0] stat_correct,
  output logic [stat_bits-1:0] stat_wrong
);

  lookup_if #(.hist_bits(hist_bits))       stage_bus ();
  table_update_if #(.hist_bits(hist_bits)) upd_bus ();

  logic [hist_bits-1:0]          hist;
  logic                          rd_en;
  logic [bp_pkg::index_bits-1:0] rd_index;
  logic [hist_bits-1:0]          rd_hist;
  bp_pkg::pc_u                   rd_pc;
  logic [1:0]                    rd_ctr;
  logic                          btac_hit;
  logic [bp_pkg::xlen-1:0]       btac_target;

  lookup_stage #(.hist_bits(hist_bits)) u_lookup (
    .clk         (clk),
    .rstn        (rstn),
    .query_valid (query_valid),
    .query_ready (query_ready),
    .query_pc    (query_pc),
    .query_instr (query_instr),
    .hist        (hist),
    .rd_en       (rd_en),
    .rd_index    (rd_index),
    .rd_hist     (rd_hist),
    .rd_pc       (rd_pc),
    .out         (stage_bus.src)
  );

  pattern_table #(.hist_bits(hist_bits)) u_pht (
    .clk      (clk),
    .rstn     (rstn),
    .rd_en    (rd_en),
    .rd_index (rd_index),
    .rd_hist  (rd_hist),
    .rd_ctr   (rd_ctr),
    .upd      (upd_bus.dst)
  );

  target_cache u_btac (
    .clk    (clk),
    .rstn   (rstn),
    .rd_en  (rd_en),
    .rd_pc  (rd_pc),
    .hit    (btac_hit),
    .target (btac_target),
    .upd    (upd_bus.dst)
  );

  select_stage #(.hist_bits(hist_bits)) u_select (
    .clk          (clk),
    .rstn         (rstn),
    .in           (stage_bus.dst),
    .ctr          (rd_ctr),
    .hit          (btac_hit),
    .target       (btac_target),
    .pred_valid   (pred_valid),
    .pred_ready   (pred_ready),
    .pred_next_pc (pred_next_pc),
    .pred_taken   (pred_taken),
    .pred_hist    (pred_hist)
  );

  resolve_stage #(.hist_bits(hist_bits), .stat_bits(stat_bits)) u_resolve (
    .clk           (clk),
    .rstn          (rstn),
    .res_valid     (res_valid),
    .res_pc        (res_pc),
    .res_hist      (res_hist),
    .res_taken     (res_taken),
    .res_target    (res_target),
    .res_pred_next (res_pred_next),
    .hist          (hist),
    .upd           (upd_bus.src),
    .stat_total    (stat_total),
    .stat_correct  (stat_correct),
    .stat_wrong    (stat_wrong)
  );

endmodule

// File: testbench/tb_branch_predictor.sv
`timescale 1ns/1ps

module tb_branch_predictor;

  localparam int hist_bits = 2;
  localparam int stat_bits = 16;

  // one data file line with its numeric columns in f
  typedef struct packed {
    logic [7:0]       kind;
    logic [7:0][31:0] f;
  } op_t;

  logic                 clk;
  logic                 rstn;
  logic                 query_valid;
  logic                 query_ready;
  logic [31:0]          query_pc;
  logic [31:0]          query_instr;
  logic                 pred_valid;
  logic                 pred_ready;
  logic [31:0]          pred_next_pc;
  logic                 pred_taken;
  logic [hist_bits-1:0] pred_hist;
  logic                 res_valid;
  logic [31:0]          res_pc;
  logic [hist_bits-1:0] res_hist;
  logic                 res_taken;
  logic [31:0]          res_target;
  logic [31:0]          res_pred_next;
  logic [stat_bits-1:0] stat_total;
  logic [stat_bits-1:0] stat_correct;
  logic [stat_bits-1:0] stat_wrong;

  op_t                  ops[$];
  logic [hist_bits-1:0] hist_model;
  logic [31:0]          rng_state;
  int                   errors;
  int                   tests_run;
  int                   tests_failed;
  int                   cycle_count;
  int                   cycle_limit;

  branch_predictor #(.hist_bits(hist_bits), .stat_bits(stat_bits)) uut (
    .clk           (clk),
    .rstn          (rstn),
    .query_valid   (query_valid),
    .query_ready   (query_ready),
    .query_pc      (query_pc),
    .query_instr   (query_instr),
    .pred_valid    (pred_valid),
    .pred_ready    (pred_ready),
    .pred_next_pc  (pred_next_pc),
    .pred_taken    (pred_taken),
    .pred_hist     (pred_hist),
    .res_valid     (res_valid),
    .res_pc        (res_pc),
    .res_hist      (res_hist),
    .res_taken     (res_taken),
    .res_target    (res_target),
    .res_pred_next (res_pred_next),
    .stat_total    (stat_total),
    .stat_correct  (stat_correct),
    .stat_wrong    (stat_wrong)
  );

  always #10 clk = ~clk;

  // watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run still busy after %0d cycles", cycle_limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int stall_cycles(input int base);
    return base + int'((next_random() >> 16) % 4);
  endfunction

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors != err_before) begin
      tests_failed++;
      $display("%s: fail", name);
    end else begin
      $display("%s: ok", name);
    end
  endtask

  task automatic load_testdata();
    int          fd;
    int          n_query;
    string       line;
    op_t         op;
    logic [31:0] v [8];
    fd = $fopen("testbench/bp_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open testbench/bp_testdata.txt");
      errors++;
    end else begin
      n_query = 0;
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) == 0) break;
        if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n") continue;
        for (int k = 0; k < 8; k++) begin
          v[k] = '0;
        end
        if ($sscanf(line, "Q %h %h %h %h", v[0], v[1], v[2], v[3]) == 4) begin
          op.kind = "Q";
          n_query++;
        end else if ($sscanf(line, "R %h %h %h %h %h %h %h %h", v[0], v[1], v[2], v[3],
                             v[4], v[5], v[6], v[7]) == 8) begin
          op.kind = "R";
        end else begin
          $display("data file line could not be read: %s", line);
          errors++;
          continue;
        end
        for (int k = 0; k < 8; k++) begin
          op.f[k] = v[k];
        end
        ops.push_back(op);
      end
      $fclose(fd);
      // 20 cycles per operation plus the longest stall per query
      cycle_limit = ops.size() * 20 + n_query * 6 + 10;
    end
  endtask

  task automatic check_prediction(input int idx);
    op_t   op;
    int    err_before;
    string name;
    op = ops[idx];
    err_before = errors;
    name = $sformatf("op%0d query pc %08h", idx, op.f[0]);
    assert (pred_taken == op.f[2][0]) else begin
      $display("ERROR %s taken expected %0d actual %0d", name, op.f[2][0], pred_taken);
      errors++;
    end
    assert (pred_next_pc == op.f[3]) else begin
      $display("ERROR %s next pc expected %08h actual %08h", name, op.f[3], pred_next_pc);
      errors++;
    end
    assert (pred_hist == hist_model) else begin
      $display("ERROR %s hist expected %0d actual %0d", name, hist_model, pred_hist);
      errors++;
    end
    finish_test(name, err_before);
  endtask

  // back to back queries with answers in order under random stalls
  task automatic run_burst(input int first, input int last);
    int  count;
    int  sent;
    int  got;
    int  stall;
    int  err_before;
    bit  saw_full;
    bit  q_fire;
    bit  p_fire;
    op_t op;
    count = last - first;
    sent = 0;
    got = 0;
    saw_full = 0;
    err_before = errors;
    // hold the first answer long enough to fill both stages
    stall = (count > 1) ? stall_cycles(2) : stall_cycles(0);
    while (got < count) begin
      @(negedge clk);
      pred_ready = (stall == 0);
      query_valid = (sent < count);
      if (sent < count) begin
        op = ops[first + sent];
        query_pc = op.f[0];
        query_instr = op.f[1];
      end
      #1;
      q_fire = query_valid && query_ready;
      p_fire = pred_valid && pred_ready;
      if (query_valid && !query_ready) saw_full = 1;
      if (pred_valid && stall > 0) stall--;
      if (p_fire) begin
        check_prediction(first + got);
        got++;
        stall = stall_cycles(0);
      end
      if (q_fire) sent++;
    end
    @(negedge clk);
    query_valid = 0;
    pred_ready = 0;
    if (count > 1) begin
      assert (saw_full) else begin
        $display("query_ready never dropped during the burst starting at op%0d", first);
        errors++;
      end
      finish_test($sformatf("burst from op%0d back-pressure", first), err_before);
    end
  endtask

  task automatic do_resolve(input int idx);
    op_t   op;
    int    err_before;
    string name;
    op = ops[idx];
    err_before = errors;
    name = $sformatf("op%0d resolve pc %08h", idx, op.f[0]);
    @(negedge clk);
    res_valid = 1;
    res_pc = op.f[0];
    res_hist = op.f[1][hist_bits-1:0];
    res_taken = op.f[2][0];
    res_target = op.f[3];
    res_pred_next = op.f[4];
    @(negedge clk);
    res_valid = 0;
    // update lands one edge after the accept
    @(negedge clk);
    hist_model = {hist_model[hist_bits-2:0], op.f[2][0]};
    assert (stat_total == op.f[5][stat_bits-1:0]) else begin
      $display("ERROR %s total expected %0d actual %0d", name, op.f[5], stat_total);
      errors++;
    end
    assert (stat_correct == op.f[6][stat_bits-1:0]) else begin
      $display("ERROR %s correct expected %0d actual %0d", name, op.f[6], stat_correct);
      errors++;
    end
    assert (stat_wrong == op.f[7][stat_bits-1:0]) else begin
      $display("ERROR %s wrong expected %0d actual %0d", name, op.f[7], stat_wrong);
      errors++;
    end
    finish_test(name, err_before);
  endtask

  initial begin
    int i;
    int j;
    int err_before;
    clk = 0;
    rstn = 1;
    query_valid = 0;
    query_pc = '0;
    query_instr = '0;
    pred_ready = 0;
    res_valid = 0;
    res_pc = '0;
    res_hist = '0;
    res_taken = 0;
    res_target = '0;
    res_pred_next = '0;
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    cycle_count = 0;
    cycle_limit = 1000;
    hist_model = '0;
    rng_state = 32'h6b6aabd2;
    load_testdata();
    repeat (2) @(negedge clk);
    rstn = 0;
    @(negedge clk);
    err_before = errors;
    assert (!pred_valid && query_ready) else begin
      $display("ERROR reset_state valid/ready expected 0/1 actual %0d/%0d",
               pred_valid, query_ready);
      errors++;
    end
    assert (stat_total == 0 && stat_correct == 0 && stat_wrong == 0) else begin
      $display("ERROR reset_state stats expected 0 0 0 actual %0d %0d %0d",
               stat_total, stat_correct, stat_wrong);
      errors++;
    end
    finish_test("reset_state", err_before);
    i = 0;
    while (i < ops.size()) begin
      if (ops[i].kind == "R") begin
        do_resolve(i);
        i++;
      end else begin
        j = i;
        while (j < ops.size() && ops[j].kind == "Q") j++;
        run_burst(i, j);
        i = j;
      end
    end
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/bp_testdata.txt
# Q pc instr exp_taken exp_next_pc
# R pc hist taken target pred_next exp_total exp_correct exp_wrong   (all hex)
# cold start, two in-flight copies of the jump at 1020
Q 00000010 00000013 0 00000011
Q 00001020 0000006f 0 00001021
Q 00001020 0000006f 0 00001021
Q 00001021 00000063 0 00001022
# both copies missed, BTAC written, counter 01 -> 11
R 00001020 0 1 00002000 00001021 1 0 1
R 00001020 0 1 00002000 00001021 2 0 2
# history is now 11, untouched counter
Q 00001020 0000006f 0 00001021
# two not-taken branches bring history back to 00
R 00000050 3 0 00000000 00000051 3 1 2
R 00000050 2 0 00000000 00000051 4 2 2
Q 00001020 0000006f 1 00002000
R 00001020 0 1 00002000 00002000 5 3 2
# history 01 selects a different counter
Q 00001020 0000006f 0 00001021
R 00001020 1 1 00002000 00001021 6 3 3
Q 00001020 0000006f 0 00001021
R 00000050 3 0 00000000 00000051 7 4 3
R 00001020 2 1 00002000 00002000 8 5 3
# burst at history 01, tag mismatches at index 20
Q 00001020 0000006f 1 00002000
Q 00033020 0000006f 0 00033021
Q 00001020 00000013 0 00001021
Q 00000010 00000013 0 00000011
Q 00001020 00000067 1 00002000
Q 00000050 00000063 0 00000051
Q 00001120 0000006f 0 00001121
Q 00001020 00000063 1 00002000
# counter at history 11 saturates
R 00001020 3 1 00002000 00001021 9 5 4
Q 00001020 0000006f 1 00002000
R 00001020 3 1 00002000 00002000 a 6 4
R 00001020 3 1 00002000 00002000 b 7 4
Q 00001020 0000006f 1 00002000
R 00001020 3 1 00002000 00002000 c 8 4
Q 00001020 0000006f 1 00002000

// File: filelist.f
hdl/bp_pkg.sv
hdl/bp_stage_if.sv
hdl/pattern_table.sv
hdl/target_cache.sv
hdl/lookup_stage.sv
hdl/select_stage.sv
hdl/resolve_stage.sv
hdl/branch_predictor.sv
testbench/tb_branch_predictor.sv

// File: Bender.yml
package:
  name: branch_predictor

sources:
  # package and interfaces first
  - hdl/bp_pkg.sv
  - hdl/bp_stage_if.sv
  - hdl/pattern_table.sv
  - hdl/target_cache.sv
  - hdl/lookup_stage.sv
  - hdl/select_stage.sv
  - hdl/resolve_stage.sv
  - hdl/branch_predictor.sv
  - target: test
    files:
      - testbench/tb_branch_predictor.sv
